/* hdl/core_pkg.sv */
`default_nettype none

package core_pkg;

  // Datapath width
  localparam int gpr_size = 32;

  // Immediate width, zero-extended to gpr_size
  localparam int imm_size = 12;

  // ALU operation encoding
  typedef enum logic [2:0] {
    ADD = 3'd0,
    SUB = 3'd1,
    AND = 3'd2,
    ORR = 3'd3,
    EOR = 3'd4,
    MOV = 3'd5,
    ADC = 3'd6,
    LSL = 3'd7
  } alu_op_t;

  // Condition flags, n in the top bit
  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } nzcv_t;

endpackage

`default_nettype wire

/* hdl/reg_rename_file.sv */
`timescale 1ns/1ns
`default_nettype none

module reg_rename_file #(
  parameter int gpr_count = 8,
  parameter int rob_depth = 8,
  localparam int idx_w = $clog2(gpr_count),
  localparam int tag_w = $clog2(rob_depth)
) (
  input  logic                          in_clk,
  input  logic                          in_rst,
  // Dispatch from decode
  input  logic                          d_valid,
  input  logic                          d_ready,
  input  core_pkg::alu_op_t             d_op,
  input  logic [idx_w-1:0]              d_dst,
  input  logic [idx_w-1:0]              d_src1,
  input  logic [idx_w-1:0]              d_src2,
  input  logic                          d_use_imm,
  input  logic [core_pkg::imm_size-1:0] d_imm,
  input  logic                          d_set_nzcv,
  input  logic                          d_uses_nzcv,
  // Tail slot from the ROB
  input  logic [tag_w-1:0]              alloc_tag,
  input  logic                          alloc_fire,
  // In-order commit from the ROB
  input  logic                          commit_valid,
  input  logic [tag_w-1:0]              commit_tag,
  input  logic [idx_w-1:0]              commit_reg,
  input  logic [core_pkg::gpr_size-1:0] commit_value,
  input  logic                          commit_set_nzcv,
  input  core_pkg::nzcv_t               commit_nzcv,
  // Architectural read-back
  input  logic [idx_w-1:0]              rd_idx,
  // Dispatch stage towards the ROB
  output logic                          alloc_valid,
  output core_pkg::alu_op_t             alloc_op,
  output logic [idx_w-1:0]              alloc_dst,
  output logic                          alloc_set_nzcv,
  output logic                          alloc_uses_nzcv,
  output logic [core_pkg::gpr_size-1:0] alloc_src1_value,
  output logic                          alloc_src1_ready,
  output logic [tag_w-1:0]              alloc_src1_tag,
  output logic [core_pkg::gpr_size-1:0] alloc_src2_value,
  output logic                          alloc_src2_ready,
  output logic [tag_w-1:0]              alloc_src2_tag,
  output core_pkg::nzcv_t               alloc_nzcv,
  output logic                          alloc_nzcv_ready,
  output logic [tag_w-1:0]              alloc_nzcv_tag,
  output logic [core_pkg::gpr_size-1:0] rd_value
);

  // Committed values, busy bits and producer tags
  logic [core_pkg::gpr_size-1:0] regs [gpr_count];
  logic [gpr_count-1:0]          busy;
  logic [tag_w-1:0]              tags [gpr_count];

  // Flags renamed as one extra register
  core_pkg::nzcv_t  flags;
  logic             flags_busy;
  logic [tag_w-1:0] flags_tag;

  // Dispatch stage buffer
  logic                          q_valid;
  core_pkg::alu_op_t             q_op;
  logic [idx_w-1:0]              q_dst;
  logic [idx_w-1:0]              q_src1;
  logic [idx_w-1:0]              q_src2;
  logic                          q_use_imm;
  logic [core_pkg::imm_size-1:0] q_imm;
  logic                          q_set_nzcv;
  logic                          q_uses_nzcv;

  always_ff @(posedge in_clk) begin
    if (in_rst) begin
      q_valid <= 1'b0;
    end else begin
      q_valid <= d_valid && d_ready;
    end
  end

  // Payload only loads on acceptance
  always_ff @(posedge in_clk) begin
    if (d_valid && d_ready) begin
      q_op        <= d_op;
      q_dst       <= d_dst;
      q_src1      <= d_src1;
      q_src2      <= d_src2;
      q_use_imm   <= d_use_imm;
      q_imm       <= d_imm;
      q_set_nzcv  <= d_set_nzcv;
      q_uses_nzcv <= d_uses_nzcv;
    end
  end

  always_ff @(posedge in_clk) begin
    if (in_rst) begin
      for (int i = 0; i < gpr_count; i++) begin
        regs[i] <= '0;
        tags[i] <= '0;
      end
      busy       <= '0;
      flags      <= '0;
      flags_busy <= 1'b0;
      flags_tag  <= '0;
    end else begin
      // Commit first so a same-cycle rename wins the busy bit
      if (commit_valid) begin
        regs[commit_reg] <= commit_value;
        // Only the newest producer frees the register
        if (tags[commit_reg] == commit_tag) begin
          busy[commit_reg] <= 1'b0;
        end
        if (commit_set_nzcv) begin
          flags <= commit_nzcv;
          if (flags_tag == commit_tag) begin
            flags_busy <= 1'b0;
          end
        end
      end
      // Rename destination to the new ROB slot
      if (alloc_fire) begin
        busy[q_dst] <= 1'b1;
        tags[q_dst] <= alloc_tag;
        if (q_set_nzcv) begin
          flags_busy <= 1'b1;
          flags_tag  <= alloc_tag;
        end
      end
    end
  end

  // Lookup sees the mapping before this instruction renames
  assign alloc_valid      = q_valid;
  assign alloc_op         = q_op;
  assign alloc_dst        = q_dst;
  assign alloc_set_nzcv   = q_set_nzcv;
  assign alloc_uses_nzcv  = q_uses_nzcv;

  assign alloc_src1_value = regs[q_src1];
  assign alloc_src1_ready = !busy[q_src1];
  assign alloc_src1_tag   = tags[q_src1];

  // Immediate is always ready
  assign alloc_src2_value = q_use_imm ?
      {{(core_pkg::gpr_size - core_pkg::imm_size){1'b0}}, q_imm} : regs[q_src2];
  assign alloc_src2_ready = q_use_imm || !busy[q_src2];
  assign alloc_src2_tag   = tags[q_src2];

  assign alloc_nzcv       = flags;
  assign alloc_nzcv_ready = !flags_busy;
  assign alloc_nzcv_tag   = flags_tag;

  assign rd_value         = regs[rd_idx];

  // A free register never still names the committing slot
  a_commit_tag : assert property (@(posedge in_clk) disable iff (in_rst)
      commit_valid && !busy[commit_reg] |-> tags[commit_reg] != commit_tag);

endmodule

`default_nettype wire

/* hdl/reorder_buffer.sv */
`timescale 1ns/1ns
`default_nettype none

module reorder_buffer #(
  parameter int gpr_count = 8,
  parameter int rob_depth = 8,
  localparam int idx_w = $clog2(gpr_count),
  localparam int tag_w = $clog2(rob_depth),
  localparam int cnt_w = tag_w + 1
) (
  input  logic                          in_clk,
  input  logic                          in_rst,
  // Dispatch stage from the rename file
  input  logic                          alloc_valid,
  input  core_pkg::alu_op_t             alloc_op,
  input  logic [idx_w-1:0]              alloc_dst,
  input  logic                          alloc_set_nzcv,
  input  logic                          alloc_uses_nzcv,
  input  logic [core_pkg::gpr_size-1:0] alloc_src1_value,
  input  logic                          alloc_src1_ready,
  input  logic [tag_w-1:0]              alloc_src1_tag,
  input  logic [core_pkg::gpr_size-1:0] alloc_src2_value,
  input  logic                          alloc_src2_ready,
  input  logic [tag_w-1:0]              alloc_src2_tag,
  input  core_pkg::nzcv_t               alloc_nzcv,
  input  logic                          alloc_nzcv_ready,
  input  logic [tag_w-1:0]              alloc_nzcv_tag,
  // Result broadcast
  input  logic                          wb_valid,
  input  logic [tag_w-1:0]              wb_tag,
  input  logic [core_pkg::gpr_size-1:0] wb_value,
  input  core_pkg::nzcv_t               wb_nzcv,
  input  logic                          retire_hold,
  output logic [tag_w-1:0]              alloc_tag,
  output logic                          alloc_fire,
  output logic                          d_ready,
  // Issue to the ALU
  output logic                          issue_valid,
  output core_pkg::alu_op_t             issue_op,
  output logic [core_pkg::gpr_size-1:0] issue_a,
  output logic [core_pkg::gpr_size-1:0] issue_b,
  output core_pkg::nzcv_t               issue_nzcv,
  output logic [tag_w-1:0]              issue_tag,
  // In-order commit
  output logic                          commit_valid,
  output logic [tag_w-1:0]              commit_tag,
  output logic [idx_w-1:0]              commit_reg,
  output logic [core_pkg::gpr_size-1:0] commit_value,
  output logic                          commit_set_nzcv,
  output core_pkg::nzcv_t               commit_nzcv
);

  logic [tag_w-1:0] head;
  logic [tag_w-1:0] tail;
  logic [cnt_w-1:0] count;
  logic [cnt_w-1:0] occupied;
  logic             full;

  // Per-entry control
  logic [rob_depth-1:0] e_valid;
  logic [rob_depth-1:0] e_issued;
  logic [rob_depth-1:0] e_done;

  // Per-entry payload
  core_pkg::alu_op_t             e_op    [rob_depth];
  logic [core_pkg::gpr_size-1:0] e_a     [rob_depth];
  logic                          e_a_rdy [rob_depth];
  logic [tag_w-1:0]              e_a_tag [rob_depth];
  logic [core_pkg::gpr_size-1:0] e_b     [rob_depth];
  logic                          e_b_rdy [rob_depth];
  logic [tag_w-1:0]              e_b_tag [rob_depth];
  core_pkg::nzcv_t               e_f     [rob_depth];
  logic                          e_f_rdy [rob_depth];
  logic [tag_w-1:0]              e_f_tag [rob_depth];
  logic                          e_need_f[rob_depth];
  logic                          e_set_f [rob_depth];
  logic [idx_w-1:0]              e_dst   [rob_depth];
  logic [core_pkg::gpr_size-1:0] e_res   [rob_depth];
  core_pkg::nzcv_t               e_res_f [rob_depth];

  // Resolved sources at allocation, ready bit on top
  logic [core_pkg::gpr_size:0] src1_res;
  logic [core_pkg::gpr_size:0] src2_res;
  core_pkg::nzcv_t             nzcv_val;
  logic                        nzcv_rdy;
  logic [tag_w-1:0]            scan;

  // Bypass from this cycle's broadcast, then from finished entries
  function automatic logic [core_pkg::gpr_size:0] resolve(
      input logic rdy, input logic [core_pkg::gpr_size-1:0] val, input logic [tag_w-1:0] tag);
    if (rdy) return {1'b1, val};
    if (wb_valid && wb_tag == tag) return {1'b1, wb_value};
    if (e_done[tag]) return {1'b1, e_res[tag]};
    return {1'b0, val};
  endfunction

  always_comb begin
    src1_res = resolve(alloc_src1_ready, alloc_src1_value, alloc_src1_tag);
    src2_res = resolve(alloc_src2_ready, alloc_src2_value, alloc_src2_tag);
    nzcv_val = alloc_nzcv;
    nzcv_rdy = alloc_nzcv_ready;
    if (!alloc_nzcv_ready) begin
      if (wb_valid && wb_tag == alloc_nzcv_tag) begin
        nzcv_val = wb_nzcv;
        nzcv_rdy = 1'b1;
      end else if (e_done[alloc_nzcv_tag]) begin
        nzcv_val = e_res_f[alloc_nzcv_tag];
        nzcv_rdy = 1'b1;
      end
    end
  end

  // Space is reserved one cycle ahead for the dispatch stage
  assign occupied   = count + cnt_w'(alloc_valid);
  assign full       = count == cnt_w'(rob_depth);
  assign d_ready    = occupied < cnt_w'(rob_depth);
  assign alloc_fire = alloc_valid && !full;
  assign alloc_tag  = tail;

  // Oldest-first scan starting at head
  always_comb begin
    issue_valid = 1'b0;
    issue_tag   = head;
    scan        = head;
    for (int k = 0; k < rob_depth; k++) begin
      scan = head + tag_w'(k);
      if (!issue_valid && e_valid[scan] && !e_issued[scan] && e_a_rdy[scan] &&
          e_b_rdy[scan] && (!e_need_f[scan] || e_f_rdy[scan])) begin
        issue_valid = 1'b1;
        issue_tag   = scan;
      end
    end
  end

  assign issue_op        = e_op[issue_tag];
  assign issue_a         = e_a[issue_tag];
  assign issue_b         = e_b[issue_tag];
  assign issue_nzcv      = e_f[issue_tag];

  assign commit_valid    = e_valid[head] && e_done[head] && !retire_hold;
  assign commit_tag      = head;
  assign commit_reg      = e_dst[head];
  assign commit_value    = e_res[head];
  assign commit_set_nzcv = e_set_f[head];
  assign commit_nzcv     = e_res_f[head];

  always_ff @(posedge in_clk) begin
    if (in_rst) begin
      head     <= '0;
      tail     <= '0;
      count    <= '0;
      e_valid  <= '0;
      e_issued <= '0;
      e_done   <= '0;
    end else begin
      if (wb_valid) begin
        e_done[wb_tag] <= 1'b1;
      end
      if (issue_valid) begin
        e_issued[issue_tag] <= 1'b1;
      end
      if (commit_valid) begin
        e_valid[head] <= 1'b0;
        head          <= head + 1'b1;
      end
      if (alloc_fire) begin
        e_valid[tail]  <= 1'b1;
        e_issued[tail] <= 1'b0;
        e_done[tail]   <= 1'b0;
        tail           <= tail + 1'b1;
      end
      count <= count + cnt_w'(alloc_fire) - cnt_w'(commit_valid);
    end
  end

  always_ff @(posedge in_clk) begin
    if (wb_valid) begin
      e_res[wb_tag]   <= wb_value;
      e_res_f[wb_tag] <= wb_nzcv;
      // Wake every waiting operand of the broadcast tag
      for (int i = 0; i < rob_depth; i++) begin
        if (e_valid[i] && !e_a_rdy[i] && e_a_tag[i] == wb_tag) begin
          e_a[i]     <= wb_value;
          e_a_rdy[i] <= 1'b1;
        end
        if (e_valid[i] && !e_b_rdy[i] && e_b_tag[i] == wb_tag) begin
          e_b[i]     <= wb_value;
          e_b_rdy[i] <= 1'b1;
        end
        if (e_valid[i] && !e_f_rdy[i] && e_f_tag[i] == wb_tag) begin
          e_f[i]     <= wb_nzcv;
          e_f_rdy[i] <= 1'b1;
        end
      end
    end
    if (alloc_fire) begin
      e_op[tail]     <= alloc_op;
      e_a[tail]      <= src1_res[core_pkg::gpr_size-1:0];
      e_a_rdy[tail]  <= src1_res[core_pkg::gpr_size];
      e_a_tag[tail]  <= alloc_src1_tag;
      e_b[tail]      <= src2_res[core_pkg::gpr_size-1:0];
      e_b_rdy[tail]  <= src2_res[core_pkg::gpr_size];
      e_b_tag[tail]  <= alloc_src2_tag;
      e_f[tail]      <= nzcv_val;
      e_f_rdy[tail]  <= nzcv_rdy;
      e_f_tag[tail]  <= alloc_nzcv_tag;
      // Setters wait too, logical ops pass C and V through
      e_need_f[tail] <= alloc_uses_nzcv || alloc_set_nzcv;
      e_set_f[tail]  <= alloc_set_nzcv;
      e_dst[tail]    <= alloc_dst;
    end
  end

  // Dispatch credit keeps the rename stage from overrunning
  a_no_alloc_full : assert property (@(posedge in_clk) disable iff (in_rst)
      alloc_valid |-> !full);

  // A slot whose result is out or on the bus never goes to the ALU again
  a_no_reissue : assert property (@(posedge in_clk) disable iff (in_rst)
      issue_valid |-> !e_done[issue_tag] && !(wb_valid && wb_tag == issue_tag));

endmodule

`default_nettype wire

/* hdl/alu_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module alu_unit #(
  parameter int rob_depth = 8,
  localparam int tag_w = $clog2(rob_depth)
) (
  input  logic                          in_clk,
  input  logic                          in_rst,
  input  logic                          issue_valid,
  input  core_pkg::alu_op_t             issue_op,
  input  logic [core_pkg::gpr_size-1:0] issue_a,
  input  logic [core_pkg::gpr_size-1:0] issue_b,
  input  core_pkg::nzcv_t               issue_nzcv,
  input  logic [tag_w-1:0]              issue_tag,
  output logic                          wb_valid,
  output logic [tag_w-1:0]              wb_tag,
  output logic [core_pkg::gpr_size-1:0] wb_value,
  output core_pkg::nzcv_t               wb_nzcv
);

  localparam int msb = core_pkg::gpr_size - 1;

  logic [msb:0]    b_eff;
  logic [msb:0]    sum;
  logic [msb:0]    result;
  logic            carry_in;
  logic            carry_out;
  logic            ovf;
  logic            arith;
  core_pkg::nzcv_t flags;

  always_comb begin
    // One adder for ADD, SUB and ADC
    b_eff = (issue_op == core_pkg::SUB) ? ~issue_b : issue_b;
    case (issue_op)
      core_pkg::SUB: carry_in = 1'b1;
      core_pkg::ADC: carry_in = issue_nzcv.c;
      default:       carry_in = 1'b0;
    endcase
    {carry_out, sum} = {1'b0, issue_a} + {1'b0, b_eff} + {{msb + 1{1'b0}}, carry_in};
    ovf   = (issue_a[msb] == b_eff[msb]) && (sum[msb] != issue_a[msb]);
    arith = issue_op inside {core_pkg::ADD, core_pkg::SUB, core_pkg::ADC};
    case (issue_op)
      core_pkg::AND: result = issue_a & issue_b;
      core_pkg::ORR: result = issue_a | issue_b;
      core_pkg::EOR: result = issue_a ^ issue_b;
      core_pkg::MOV: result = issue_b;
      core_pkg::LSL: result = issue_a << issue_b[4:0];
      default:       result = sum;
    endcase
    flags.n = result[msb];
    flags.z = result == '0;
    // Non-arithmetic ops keep incoming C and V
    flags.c = arith ? carry_out : issue_nzcv.c;
    flags.v = arith ? ovf : issue_nzcv.v;
  end

  always_ff @(posedge in_clk) begin
    if (in_rst) begin
      wb_valid <= 1'b0;
    end else begin
      wb_valid <= issue_valid;
    end
  end

  always_ff @(posedge in_clk) begin
    if (issue_valid) begin
      wb_tag   <= issue_tag;
      wb_value <= result;
      wb_nzcv  <= flags;
    end
  end

  // No stray broadcast out of reset
  a_quiet_reset : assert property (@(posedge in_clk) in_rst |=> !wb_valid);

endmodule

`default_nettype wire

/* hdl/ooo_core_top.sv */
`timescale 1ns/1ns
`default_nettype none

module ooo_core_top #(
  parameter int gpr_count = 8,
  parameter int rob_depth = 8,
  localparam int idx_w = $clog2(gpr_count),
  localparam int tag_w = $clog2(rob_depth)
) (
  input  logic                          in_clk,
  input  logic                          in_rst,
  input  logic                          d_valid,
  input  core_pkg::alu_op_t             d_op,
  input  logic [idx_w-1:0]              d_dst,
  input  logic [idx_w-1:0]              d_src1,
  input  logic [idx_w-1:0]              d_src2,
  input  logic                          d_use_imm,
  input  logic [core_pkg::imm_size-1:0] d_imm,
  input  logic                          d_set_nzcv,
  input  logic                          d_uses_nzcv,
  output logic                          d_ready,
  input  logic                          retire_hold,
  output logic                          commit_valid,
  output logic [tag_w-1:0]              commit_tag,
  output logic [idx_w-1:0]              commit_reg,
  output logic [core_pkg::gpr_size-1:0] commit_value,
  output logic                          commit_set_nzcv,
  output core_pkg::nzcv_t               commit_nzcv,
  input  logic [idx_w-1:0]              rd_idx,
  output logic [core_pkg::gpr_size-1:0] rd_value
);

  // Dispatch stage
  logic                          alloc_valid;
  logic                          alloc_fire;
  logic [tag_w-1:0]              alloc_tag;
  core_pkg::alu_op_t             alloc_op;
  logic [idx_w-1:0]              alloc_dst;
  logic                          alloc_set_nzcv;
  logic                          alloc_uses_nzcv;
  logic [core_pkg::gpr_size-1:0] alloc_src1_value;
  logic                          alloc_src1_ready;
  logic [tag_w-1:0]              alloc_src1_tag;
  logic [core_pkg::gpr_size-1:0] alloc_src2_value;
  logic                          alloc_src2_ready;
  logic [tag_w-1:0]              alloc_src2_tag;
  core_pkg::nzcv_t               alloc_nzcv;
  logic                          alloc_nzcv_ready;
  logic [tag_w-1:0]              alloc_nzcv_tag;

  // Issue and broadcast
  logic                          issue_valid;
  core_pkg::alu_op_t             issue_op;
  logic [core_pkg::gpr_size-1:0] issue_a;
  logic [core_pkg::gpr_size-1:0] issue_b;
  core_pkg::nzcv_t               issue_nzcv;
  logic [tag_w-1:0]              issue_tag;
  logic                          wb_valid;
  logic [tag_w-1:0]              wb_tag;
  logic [core_pkg::gpr_size-1:0] wb_value;
  core_pkg::nzcv_t               wb_nzcv;

  reg_rename_file #(.gpr_count(gpr_count), .rob_depth(rob_depth)) i_rename (
    .in_clk, .in_rst,
    .d_valid, .d_ready, .d_op, .d_dst, .d_src1, .d_src2,
    .d_use_imm, .d_imm, .d_set_nzcv, .d_uses_nzcv,
    .alloc_tag, .alloc_fire,
    .commit_valid, .commit_tag, .commit_reg, .commit_value,
    .commit_set_nzcv, .commit_nzcv,
    .rd_idx,
    .alloc_valid, .alloc_op, .alloc_dst, .alloc_set_nzcv, .alloc_uses_nzcv,
    .alloc_src1_value, .alloc_src1_ready, .alloc_src1_tag,
    .alloc_src2_value, .alloc_src2_ready, .alloc_src2_tag,
    .alloc_nzcv, .alloc_nzcv_ready, .alloc_nzcv_tag,
    .rd_value
  );

  reorder_buffer #(.gpr_count(gpr_count), .rob_depth(rob_depth)) i_rob (
    .in_clk, .in_rst,
    .alloc_valid, .alloc_op, .alloc_dst, .alloc_set_nzcv, .alloc_uses_nzcv,
    .alloc_src1_value, .alloc_src1_ready, .alloc_src1_tag,
    .alloc_src2_value, .alloc_src2_ready, .alloc_src2_tag,
    .alloc_nzcv, .alloc_nzcv_ready, .alloc_nzcv_tag,
    .wb_valid, .wb_tag, .wb_value, .wb_nzcv,
    .retire_hold,
    .alloc_tag, .alloc_fire, .d_ready,
    .issue_valid, .issue_op, .issue_a, .issue_b, .issue_nzcv, .issue_tag,
    .commit_valid, .commit_tag, .commit_reg, .commit_value,
    .commit_set_nzcv, .commit_nzcv
  );

  alu_unit #(.rob_depth(rob_depth)) i_alu (
    .in_clk, .in_rst,
    .issue_valid, .issue_op, .issue_a, .issue_b, .issue_nzcv, .issue_tag,
    .wb_valid, .wb_tag, .wb_value, .wb_nzcv
  );

endmodule

`default_nettype wire

/* test/tb_ref_model.svh */
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// One dispatched instruction as the testbench tracks it
typedef struct packed {
  core_pkg::alu_op_t             op;
  logic [idx_w-1:0]              dst;
  logic [idx_w-1:0]              src1;
  logic [idx_w-1:0]              src2;
  logic                          use_imm;
  logic [core_pkg::imm_size-1:0] imm;
  logic                          set_f;
  logic                          use_f;
} instr_t;

// Architectural state, advanced in program order
logic [dw-1:0]   model_regs [gpr_count];
core_pkg::nzcv_t model_flags;

function automatic void model_reset();
  for (int i = 0; i < gpr_count; i++) begin
    model_regs[i] = '0;
  end
  model_flags = '0;
endfunction

// Result and flags of one operation
function automatic void eval_op(
    input core_pkg::alu_op_t op, input logic [dw-1:0] a, input logic [dw-1:0] b,
    input core_pkg::nzcv_t fin, output logic [dw-1:0] res, output core_pkg::nzcv_t fout);
  logic [dw:0] wide;
  // C and V carry over unless the op is arithmetic
  fout = fin;
  res  = '0;
  case (op)
    core_pkg::ADD, core_pkg::ADC: begin
      wide = {1'b0, a} + {1'b0, b};
      if (op == core_pkg::ADC) begin
        wide = wide + (dw + 1)'(fin.c);
      end
      res    = wide[dw-1:0];
      fout.c = wide[dw];
      // Same-sign operands giving an opposite-sign sum
      fout.v = (a[dw-1] == b[dw-1]) && (res[dw-1] != a[dw-1]);
    end
    core_pkg::SUB: begin
      res = a - b;
      // Carry means no borrow
      fout.c = a >= b;
      fout.v = (a[dw-1] != b[dw-1]) && (res[dw-1] != a[dw-1]);
    end
    core_pkg::AND: res = a & b;
    core_pkg::ORR: res = a | b;
    core_pkg::EOR: res = a ^ b;
    core_pkg::MOV: res = b;
    core_pkg::LSL: res = a << b[4:0];
    default:       res = '0;
  endcase
  fout.n = res[dw-1];
  fout.z = res == '0;
endfunction

// Execute the next instruction on the model
function automatic void model_exec(
    input instr_t ins, output logic [dw-1:0] res, output core_pkg::nzcv_t fout);
  logic [dw-1:0] b;
  b = ins.use_imm ? dw'(ins.imm) : model_regs[ins.src2];
  eval_op(ins.op, model_regs[ins.src1], b, model_flags, res, fout);
  model_regs[ins.dst] = res;
  if (ins.set_f) begin
    model_flags = fout;
  end
endfunction

`endif

/* test/tb_ooo_core.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_ooo_core;

  localparam int gpr_count      = 8;
  localparam int rob_depth      = 8;
  localparam int idx_w          = $clog2(gpr_count);
  localparam int tag_w          = $clog2(rob_depth);
  localparam int dw             = core_pkg::gpr_size;
  localparam int imm_w          = core_pkg::imm_size;
  localparam int n_instr        = 300;
  localparam int timeout_cycles = n_instr * 20 + 200;

  `include "tb_ref_model.svh"

  logic                          in_clk;
  logic                          in_rst;
  logic                          d_valid;
  core_pkg::alu_op_t             d_op;
  logic [idx_w-1:0]              d_dst;
  logic [idx_w-1:0]              d_src1;
  logic [idx_w-1:0]              d_src2;
  logic                          d_use_imm;
  logic [core_pkg::imm_size-1:0] d_imm;
  logic                          d_set_nzcv;
  logic                          d_uses_nzcv;
  logic                          d_ready;
  logic                          retire_hold;
  logic                          commit_valid;
  logic [tag_w-1:0]              commit_tag;
  logic [idx_w-1:0]              commit_reg;
  logic [dw-1:0]                 commit_value;
  logic                          commit_set_nzcv;
  core_pkg::nzcv_t               commit_nzcv;
  logic [idx_w-1:0]              rd_idx;
  logic [dw-1:0]                 rd_value;

  // Accepted and not yet committed, oldest first
  instr_t           expected [$];
  logic [idx_w-1:0] recent [3];
  integer           seed;
  // Commits seen since reset
  int               commits;

  ooo_core_top i_dut (
    .in_clk, .in_rst,
    .d_valid, .d_op, .d_dst, .d_src1, .d_src2,
    .d_use_imm, .d_imm, .d_set_nzcv, .d_uses_nzcv,
    .d_ready, .retire_hold,
    .commit_valid, .commit_tag, .commit_reg, .commit_value,
    .commit_set_nzcv, .commit_nzcv,
    .rd_idx, .rd_value
  );

  always #4 in_clk = ~in_clk;

  task automatic end_in_failure();
    $display("sim failed");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_eq(input string name, input logic [dw-1:0] got,
      input logic [dw-1:0] exp);
    assert (got === exp) else begin
      $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
      end_in_failure();
    end
  endtask

  // Non-negative draw below n
  function automatic int pick(input int n);
    return ($random(seed) & 32'h7fff_ffff) % n;
  endfunction

  function automatic instr_t random_instr(input bit biased);
    instr_t ins;
    ins.op      = core_pkg::alu_op_t'(pick(8));
    ins.dst     = idx_w'(pick(gpr_count));
    // Biased sources chase the last three results
    ins.src1    = biased ? recent[pick(3)] : idx_w'(pick(gpr_count));
    ins.src2    = biased ? recent[pick(3)] : idx_w'(pick(gpr_count));
    ins.use_imm = pick(4) == 0;
    ins.imm     = imm_w'($random(seed));
    ins.set_f   = biased ? pick(3) != 0 : pick(2) == 0;
    ins.use_f   = ins.op == core_pkg::ADC;
    // Some read their own destination
    if (pick(8) == 0) begin
      ins.src1 = ins.dst;
    end
    recent[2] = recent[1];
    recent[1] = recent[0];
    recent[0] = ins.dst;
    return ins;
  endfunction

  task automatic drive_instr(input instr_t ins);
    d_op        = ins.op;
    d_dst       = ins.dst;
    d_src1      = ins.src1;
    d_src2      = ins.src2;
    d_use_imm   = ins.use_imm;
    d_imm       = ins.imm;
    d_set_nzcv  = ins.set_f;
    d_uses_nzcv = ins.use_f;
  endtask

  // Hold the instruction until d_ready is seen before an edge
  task automatic send(input instr_t ins, input bit vary_hold);
    bit taken;
    taken = 1'b0;
    drive_instr(ins);
    d_valid = 1'b1;
    while (!taken) begin
      @(negedge in_clk);
      taken = d_ready;
      @(posedge in_clk);
      #1;
      if (vary_hold) begin
        retire_hold = pick(4) == 0;
      end
    end
    expected.push_back(ins);
    d_valid = 1'b0;
  endtask

  task automatic wait_drain();
    while (expected.size() != 0) begin
      @(posedge in_clk);
    end
    #1;
  endtask

  // Commit outputs settle well before the falling edge
  always @(negedge in_clk) begin : commit_check
    instr_t          ins;
    logic [dw-1:0]   exp_value;
    core_pkg::nzcv_t exp_flags;
    if (!in_rst && commit_valid) begin
      assert (expected.size() != 0) else begin
        $display("a commit arrived at %0t with no instruction outstanding", $time);
        end_in_failure();
      end
      ins = expected.pop_front();
      model_exec(ins, exp_value, exp_flags);
      // Slots are handed out round the ring from zero and never flushed
      check_eq("commit_tag", dw'(commit_tag), dw'(commits % rob_depth));
      commits++;
      check_eq("commit_reg", dw'(commit_reg), dw'(ins.dst));
      check_eq("commit_value", commit_value, exp_value);
      check_eq("commit_set_nzcv", dw'(commit_set_nzcv), dw'(ins.set_f));
      if (ins.set_f) begin
        check_eq("commit_nzcv", dw'(commit_nzcv), dw'(exp_flags));
      end
    end
  end

  initial begin : watchdog
    repeat (timeout_cycles) @(posedge in_clk);
    $display("timeout after %0d cycles without the program draining", timeout_cycles);
    end_in_failure();
  end

  initial begin : stimulus
    instr_t ins;
    bit     taken;
    int     accepted;
    seed        = 32'h2fd;
    commits     = 0;
    in_clk      = 1'b0;
    in_rst      = 1'b1;
    d_valid     = 1'b0;
    retire_hold = 1'b0;
    rd_idx      = '0;
    recent[0]   = '0;
    recent[1]   = '0;
    recent[2]   = '0;
    drive_instr('0);
    model_reset();
    repeat (3) @(posedge in_clk);
    #1;
    in_rst = 1'b0;

    // Uniform program with idle gaps
    for (int i = 0; i < 140; i++) begin
      send(random_instr(1'b0), 1'b0);
      if (pick(5) == 0) begin
        @(posedge in_clk);
        #1;
      end
    end

    // Dependency chains, flag chains, random commit stalls
    for (int i = 0; i < 140; i++) begin
      send(random_instr(1'b1), 1'b1);
    end
    retire_hold = 1'b0;
    wait_drain();

    // Back-pressure with commit held
    retire_hold = 1'b1;
    accepted    = 0;
    ins         = random_instr(1'b1);
    drive_instr(ins);
    d_valid = 1'b1;
    repeat (3 * rob_depth) begin
      @(negedge in_clk);
      taken = d_ready;
      @(posedge in_clk);
      #1;
      if (taken) begin
        expected.push_back(ins);
        accepted++;
        ins = random_instr(1'b1);
        drive_instr(ins);
      end
    end
    d_valid = 1'b0;
    @(negedge in_clk);
    check_eq("d_ready", dw'(d_ready), '0);
    check_eq("accepted_count", dw'(accepted), dw'(rob_depth));
    @(posedge in_clk);
    #1;
    retire_hold = 1'b0;
    wait_drain();

    // Committed register file against the model
    for (int i = 0; i < gpr_count; i++) begin
      rd_idx = idx_w'(i);
      @(negedge in_clk);
      check_eq($sformatf("rd_value[%0d]", i), rd_value, model_regs[i]);
      @(posedge in_clk);
      #1;
    end

    $display("sim passed");
    $finish;
  end

endmodule

`default_nettype wire

/* build.f */
+incdir+test
hdl/core_pkg.sv
hdl/reg_rename_file.sv
hdl/reorder_buffer.sv
hdl/alu_unit.sv
hdl/ooo_core_top.sv
test/tb_ooo_core.sv

/* run.sh */
#!/bin/sh
# Build and run the out-of-order core testbench with Verilator.
# The exit status is nonzero if the compile fails or the simulation fails.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f build.f \
  --top-module tb_ooo_core \
  -Mdir obj_dir \
  -o sim_tb
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator compile failed with status $status"
  exit "$status"
fi

./obj_dir/sim_tb
status=$?
if [ "$status" -ne 0 ]; then
  echo "simulation failed with status $status"
  exit "$status"
fi

exit 0
